// File: immu.f
+incdir+include
logic/immu_spr_pkg.sv
logic/immu_tlb_pkg.sv
logic/tlb_dpram.sv
logic/itlb_mmu.sv
logic/fetch_xlate.sv
logic/immu_top.sv
bench/tb_immu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ITLB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f immu.f \
   --top-module tb_immu \
   -Mdir obj_dir

out=$(./obj_dir/Vtb_immu)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
   exit 0
fi
exit 1

// File: include/tb_immu_cases.svh
/*
 ITLB case table. Set indices assume set_width 6.
 Fetch rows give a page-aligned address, the bench adds a random page offset.
*/
// Columns: op, SPR address, SPR data or fetch page, ctl {en, sup, burst},
// expected read word or physical page, expected {ci, miss, pf}

// Four sets, match then translate
add_case(op_write, 16'h1205, 32'h0040_A001, 3'b000, 32'h0000_0000, 3'b000); // VA 0040A000
add_case(op_write, 16'h1285, 32'h8001_20C0, 3'b000, 32'h0000_0000, 3'b000); // uxe sxe
add_case(op_write, 16'h1209, 32'h0001_2001, 3'b000, 32'h0000_0000, 3'b000); // VA 00012000
add_case(op_write, 16'h1289, 32'h1234_6082, 3'b000, 32'h0000_0000, 3'b000); // uxe ci
add_case(op_write, 16'h120C, 32'h0FF1_8000, 3'b000, 32'h0000_0000, 3'b000); // Not valid
add_case(op_write, 16'h128C, 32'h0000_4040, 3'b000, 32'h0000_0000, 3'b000); // sxe only
add_case(op_write, 16'h1203, 32'h0000_6001, 3'b000, 32'h0000_0000, 3'b000); // VA 00006000
add_case(op_write, 16'h1283, 32'hFFFF_E000, 3'b000, 32'h0000_0000, 3'b000); // No execute

// Read back, ack in cycle two
add_case(op_read,  16'h1205, 32'h0000_0000, 3'b000, 32'h0040_A001, 3'b000);
add_case(op_read,  16'h1289, 32'h0000_0000, 3'b000, 32'h1234_6082, 3'b000);
add_case(op_read,  16'h120C, 32'h0000_0000, 3'b000, 32'h0FF1_8000, 3'b000);
add_case(op_read,  16'h1283, 32'h0000_0000, 3'b000, 32'hFFFF_E000, 3'b000);

// Hits, all four mode and enable combinations
add_case(op_fetch, 16'h0000, 32'h0040_A000, 3'b110, 32'h8001_2000, 3'b000);
add_case(op_fetch, 16'h0000, 32'h0001_2000, 3'b100, 32'h1234_6000, 3'b100);
add_case(op_fetch, 16'h0000, 32'h0001_2000, 3'b110, 32'h1234_6000, 3'b101); // sxe 0
add_case(op_fetch, 16'h0000, 32'h0000_6000, 3'b100, 32'hFFFF_E000, 3'b001); // uxe 0
add_case(op_fetch, 16'h0000, 32'h0040_A000, 3'b100, 32'h8001_2000, 3'b000);
add_case(op_fetch, 16'h0000, 32'h0000_6000, 3'b110, 32'hFFFF_E000, 3'b001);

// Misses, wrong VPN in set 5, invalid entry in set 12
add_case(op_fetch, 16'h0000, 32'h0080_A000, 3'b100, 32'h8001_2000, 3'b010);
add_case(op_fetch, 16'h0000, 32'h0FF1_8000, 3'b100, 32'h0000_4000, 3'b011);
add_case(op_fetch, 16'h0000, 32'h0FF1_8000, 3'b110, 32'h0000_4000, 3'b010);

// MMU off
add_case(op_fetch, 16'h0000, 32'h0040_A000, 3'b000, 32'h0040_A000, 3'b000);
add_case(op_fetch, 16'h0000, 32'h7654_2000, 3'b010, 32'h7654_2000, 3'b000);

// Back to back, one request per cycle
add_case(op_fetch, 16'h0000, 32'h0040_A000, 3'b111, 32'h8001_2000, 3'b000);
add_case(op_fetch, 16'h0000, 32'h0001_2000, 3'b101, 32'h1234_6000, 3'b100);
add_case(op_fetch, 16'h0000, 32'h0FF1_8000, 3'b011, 32'h0FF1_8000, 3'b000);
add_case(op_fetch, 16'h0000, 32'h0000_6000, 3'b110, 32'hFFFF_E000, 3'b001);

// Unmapped SPR, en column is the write strobe here
add_case(op_noack, 16'h1300, 32'hDEAD_BEEF, 3'b100, 32'h0000_0000, 3'b000);
add_case(op_noack, 16'h1300, 32'h0000_0000, 3'b000, 32'h0000_0000, 3'b000);
add_case(op_read,  16'h1205, 32'h0000_0000, 3'b000, 32'h0040_A001, 3'b000); // Bus still alive

// File: bench/tb_immu.sv
/*
 Testbench for immu_top with the default set_width of 6.
 Runs the case table from tb_immu_cases.svh, SPR rows one at a time,
 consecutive fetch rows flagged as burst issued in consecutive cycles.
*/
`timescale 1ns/1ps

module tb_immu;

   localparam int clk_period = 20;
   localparam logic [2:0] op_write = 3'd0;
   localparam logic [2:0] op_read  = 3'd1;
   localparam logic [2:0] op_noack = 3'd2;
   localparam logic [2:0] op_fetch = 3'd3;

   typedef struct packed {
      logic [2:0]               op;
      immu_spr_pkg::spr_addr_t  addr;
      immu_tlb_pkg::word_t      data;      // SPR write data or fetch page
      logic                     en;        // MMU enable, or write for unmapped rows
      logic                     sup;
      logic                     burst;     // Next row follows in the next cycle
      immu_tlb_pkg::word_t      exp_word;  // Read-back word or physical page
      logic                     exp_ci;
      logic                     exp_miss;
      logic                     exp_pf;
   } case_t;

   logic                     clk;
   logic                     rst;
   logic                     fetch_req_i;
   immu_tlb_pkg::word_t      fetch_addr_i;
   logic                     immu_enable_i;
   logic                     supervisor_i;
   immu_spr_pkg::spr_addr_t  spr_addr_i;
   logic                     spr_we_i;
   logic                     spr_stb_i;
   immu_tlb_pkg::word_t      spr_dat_i;
   logic                     xlate_valid_o;
   immu_tlb_pkg::word_t      phys_addr_o;
   logic                     cache_inhibit_o;
   logic                     tlb_miss_o;
   logic                     pagefault_o;
   immu_tlb_pkg::word_t      spr_dat_o;
   logic                     spr_ack_o;

   case_t        cases[$];
   logic [15:0]  lfsr_state = 16'd78;  // Offset generator seed
   int           err_count   = 0;
   int           check_count = 0;
   int           cycle_count = 0;
   int           cycle_limit = 0;     // Set once the table is loaded
   int           idx;
   int           last;

   immu_top immu_top_inst (
      .clk             (clk),
      .rst             (rst),
      .fetch_req_i     (fetch_req_i),
      .fetch_addr_i    (fetch_addr_i),
      .immu_enable_i   (immu_enable_i),
      .supervisor_i    (supervisor_i),
      .spr_addr_i      (spr_addr_i),
      .spr_we_i        (spr_we_i),
      .spr_stb_i       (spr_stb_i),
      .spr_dat_i       (spr_dat_i),
      .xlate_valid_o   (xlate_valid_o),
      .phys_addr_o     (phys_addr_o),
      .cache_inhibit_o (cache_inhibit_o),
      .tlb_miss_o      (tlb_miss_o),
      .pagefault_o     (pagefault_o),
      .spr_dat_o       (spr_dat_o),
      .spr_ack_o       (spr_ack_o)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period/2) clk = ~clk;
   end

   task automatic add_case(input logic [2:0] op, input logic [15:0] addr,
                           input immu_tlb_pkg::word_t data, input logic [2:0] ctl,
                           input immu_tlb_pkg::word_t exp_word, input logic [2:0] exp_flags);
      case_t c;
      c.op       = op;
      c.addr     = addr;
      c.data     = data;
      {c.en, c.sup, c.burst} = ctl;
      c.exp_word = exp_word;
      {c.exp_ci, c.exp_miss, c.exp_pf} = exp_flags;
      cases.push_back(c);
   endtask

   task automatic fill_case_table();
`include "tb_immu_cases.svh"
   endtask

   // 16-bit Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic draw_offset(output immu_tlb_pkg::word_t off);
      int b;
      off = '0;
      for (b = 0; b < immu_tlb_pkg::page_bits; b++) begin
         lfsr_state = lfsr_next(lfsr_state);   // One step per bit
         off[b]     = lfsr_state[0];
      end
   endtask

   function automatic string op_name(input logic [2:0] op);
      case (op)
         op_write: return "spr write";
         op_read:  return "spr read";
         op_noack: return "spr unmapped";
         default:  return "fetch";
      endcase
   endfunction

   task automatic check_word(input string name, input immu_tlb_pkg::word_t exp,
                             input immu_tlb_pkg::word_t got);
      check_count++;
      if (got !== exp) begin
         $display("Mismatch %s exp %h got %h", name, exp, got);
         err_count++;
      end
   endtask

   task automatic check_entry(input string name, input immu_tlb_pkg::tlb_word_u exp,
                              input immu_tlb_pkg::tlb_word_u got, input logic is_match);
      check_count++;
      if (got !== exp) begin
         $display("Mismatch %s exp %h got %h", name, exp, got);
         if (is_match)
            $display("   match  exp vpn %h v %b, got vpn %h v %b",
                     exp.mr.vpn, exp.mr.v, got.mr.vpn, got.mr.v);
         else
            $display("   trans  exp ppn %h uxe %b sxe %b ci %b, got ppn %h uxe %b sxe %b ci %b",
                     exp.tr.ppn, exp.tr.uxe, exp.tr.sxe, exp.tr.ci,
                     got.tr.ppn, got.tr.uxe, got.tr.sxe, got.tr.ci);
         err_count++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic got);
      check_count++;
      if (got !== exp) begin
         $display("Mismatch %s exp %h got %h", name, exp, got);
         err_count++;
      end
   endtask

   task automatic report_case(input int i, input int errs_before);
      immu_tlb_pkg::word_t where;
      where = (cases[i].op == op_fetch) ? cases[i].data : {16'h0000, cases[i].addr};
      if (err_count == errs_before)
         $display("case %0d %s %h: pass", i, op_name(cases[i].op), where);
      else
         $display("case %0d %s %h: %0d errors", i, op_name(cases[i].op), where,
                  err_count - errs_before);
   endtask

   // Strobe held until ack or four cycles, sampled a quarter period after the falling edge
   task automatic spr_access(input logic [15:0] addr, input logic we,
                             input immu_tlb_pkg::word_t data,
                             output int ack_cycle, output immu_tlb_pkg::word_t rdata);
      int n;
      ack_cycle = 0;
      rdata     = '0;
      @(negedge clk);
      spr_addr_i = addr;
      spr_we_i   = we;
      spr_dat_i  = data;
      spr_stb_i  = 1'b1;
      for (n = 1; n <= 4 && ack_cycle == 0; n++) begin
         #(clk_period/4);
         if (spr_ack_o) begin
            ack_cycle = n;
            rdata     = spr_dat_o;
         end
         @(negedge clk);
      end
      spr_stb_i = 1'b0;                      // Released on the falling edge after ack
      spr_we_i  = 1'b0;
   endtask

   task automatic run_spr_case(input int i);
      case_t                c;
      int                   ack_cycle;
      int                   exp_cycle;
      int                   errs_before;
      logic                 we;
      immu_tlb_pkg::word_t  rdata;
      c           = cases[i];
      errs_before = err_count;
      we          = (c.op == op_write) || (c.op == op_noack && c.en);
      exp_cycle   = (c.op == op_write) ? 1 : ((c.op == op_read) ? 2 : 0);
      spr_access(c.addr, we, c.data, ack_cycle, rdata);
      if (ack_cycle != exp_cycle) begin
         if (exp_cycle == 0)
            $display("SPR access to %h was acked although the address is unmapped", c.addr);
         else if (ack_cycle == 0)
            $display("SPR access to %h got no ack within 4 cycles", c.addr);
         else
            $display("SPR access to %h acked in cycle %0d instead of cycle %0d",
                     c.addr, ack_cycle, exp_cycle);
         err_count++;
      end
      if (c.op == op_read && ack_cycle == 2)
         check_entry("spr_dat_o", c.exp_word, rdata, c.addr < immu_spr_pkg::itlb_trans_base);
      report_case(i, errs_before);
   endtask

   task automatic check_fetch(input int i, input immu_tlb_pkg::word_t exp_phys);
      int errs_before;
      errs_before = err_count;
      check_flag("xlate_valid_o", 1'b1, xlate_valid_o);
      check_word("phys_addr_o", exp_phys, phys_addr_o);
      check_flag("cache_inhibit_o", cases[i].exp_ci, cache_inhibit_o);
      check_flag("tlb_miss_o", cases[i].exp_miss, tlb_miss_o);
      check_flag("pagefault_o", cases[i].exp_pf, pagefault_o);
      report_case(i, errs_before);
   endtask

   // Rows first..last issued in consecutive cycles, each result checked one cycle later
   task automatic run_fetch_burst(input int first, input int last_row);
      int                   k;
      immu_tlb_pkg::word_t  off;
      immu_tlb_pkg::word_t  exp_phys[$];
      for (k = first; k <= last_row + 1; k++) begin
         @(negedge clk);
         if (k <= last_row) begin
            draw_offset(off);
            fetch_req_i   = 1'b1;
            fetch_addr_i  = cases[k].data | off;
            immu_enable_i = cases[k].en;
            supervisor_i  = cases[k].sup;
            exp_phys.push_back(cases[k].exp_word | off);  // Page from table, offset kept
         end else begin
            fetch_req_i = 1'b0;
         end
         if (k > first) begin
            #(clk_period/4);
            check_fetch(k - 1, exp_phys.pop_front());
         end
      end
      @(negedge clk);
      #(clk_period/4);
      check_flag("xlate_valid_o", 1'b0, xlate_valid_o);  // No request, no result
   endtask

   // Watchdog
   initial begin
      wait (cycle_limit > 0);
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Run stopped after %0d cycles, the case table did not complete", cycle_count);
      $display("Test FAILED");
      $finish;
   end

   initial begin
      rst           = 1'b1;
      fetch_req_i   = 1'b0;
      fetch_addr_i  = '0;
      immu_enable_i = 1'b0;
      supervisor_i  = 1'b0;
      spr_addr_i    = '0;
      spr_we_i      = 1'b0;
      spr_stb_i     = 1'b0;
      spr_dat_i     = '0;
      fill_case_table();
      cycle_limit = cases.size() * 8 + 50;
      repeat (5) @(negedge clk);
      rst = 1'b0;

      idx = 0;
      while (idx < cases.size()) begin
         if (cases[idx].op == op_fetch) begin
            last = idx;                                    // Gather the burst
            while (cases[last].burst && last + 1 < cases.size() &&
                   cases[last + 1].op == op_fetch)
               last++;
            run_fetch_burst(idx, last);
            idx = last + 1;
         end else begin
            run_spr_case(idx);
            idx++;
         end
      end

      @(negedge clk);
      $display("Summary: %0d cases, %0d checks, %0d errors", cases.size(), check_count,
               err_count);
      if (err_count == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// File: logic/immu_top.sv
/*
 Instruction MMU top level, fetch stage plus ITLB.
 set_width selects the number of ITLB sets, 7 at most.
*/
`timescale 1ns/1ps

module immu_top #(
   parameter int set_width = 6     // 64 sets
) (
   input  logic                     clk,
   input  logic                     rst,

   // Fetch request
   input  logic                     fetch_req_i,
   input  immu_tlb_pkg::word_t      fetch_addr_i,
   input  logic                     immu_enable_i,
   input  logic                     supervisor_i,

   // SPR bus
   input  immu_spr_pkg::spr_addr_t  spr_addr_i,
   input  logic                     spr_we_i,
   input  logic                     spr_stb_i,
   input  immu_tlb_pkg::word_t      spr_dat_i,

   // Translation result
   output logic                     xlate_valid_o,
   output immu_tlb_pkg::word_t      phys_addr_o,
   output logic                     cache_inhibit_o,
   output logic                     tlb_miss_o,
   output logic                     pagefault_o,

   output immu_tlb_pkg::word_t      spr_dat_o,
   output logic                     spr_ack_o
);

   fetch_xlate #(
      .set_width (set_width)
   ) fetch_xlate_inst (
      .clk             (clk),
      .rst             (rst),
      .fetch_req_i     (fetch_req_i),
      .fetch_addr_i    (fetch_addr_i),
      .immu_enable_i   (immu_enable_i),
      .supervisor_i    (supervisor_i),
      .spr_addr_i      (spr_addr_i),
      .spr_we_i        (spr_we_i),
      .spr_stb_i       (spr_stb_i),
      .spr_dat_i       (spr_dat_i),
      .xlate_valid_o   (xlate_valid_o),
      .phys_addr_o     (phys_addr_o),
      .cache_inhibit_o (cache_inhibit_o),
      .tlb_miss_o      (tlb_miss_o),
      .pagefault_o     (pagefault_o),
      .spr_dat_o       (spr_dat_o),
      .spr_ack_o       (spr_ack_o)
   );

endmodule

// File: logic/fetch_xlate.sv
/*
 Fetch stage around the ITLB. One request per cycle, no back-pressure,
 result one cycle after the request. Translation bypassed when the MMU
 enable was low at request time.
*/
`timescale 1ns/1ps

module fetch_xlate #(
   parameter int set_width = 6
) (
   input  logic                     clk,
   input  logic                     rst,

   input  logic                     fetch_req_i,
   input  immu_tlb_pkg::word_t      fetch_addr_i,
   input  logic                     immu_enable_i,
   input  logic                     supervisor_i,

   input  immu_spr_pkg::spr_addr_t  spr_addr_i,
   input  logic                     spr_we_i,
   input  logic                     spr_stb_i,
   input  immu_tlb_pkg::word_t      spr_dat_i,

   output logic                     xlate_valid_o,
   output immu_tlb_pkg::word_t      phys_addr_o,
   output logic                     cache_inhibit_o,
   output logic                     tlb_miss_o,
   output logic                     pagefault_o,
   output immu_tlb_pkg::word_t      spr_dat_o,
   output logic                     spr_ack_o
);

   logic                 req_valid_r;
   immu_tlb_pkg::word_t  addr_r;        // Virtual address of the pending result
   logic                 enable_r;
   logic                 supervisor_r;

   immu_tlb_pkg::word_t  mmu_phys_addr;
   logic                 mmu_cache_inhibit;
   logic                 mmu_tlb_miss;
   logic                 mmu_pagefault;

   always_ff @(posedge clk) begin
      if (rst) begin
         req_valid_r <= 1'b0;
      end else begin
         req_valid_r <= fetch_req_i;
      end
   end

   // Request payload, held between requests
   always_ff @(posedge clk) begin
      if (fetch_req_i) begin
         addr_r       <= fetch_addr_i;
         enable_r     <= immu_enable_i;
         supervisor_r <= supervisor_i;
      end
   end

   itlb_mmu #(
      .set_width (set_width)
   ) itlb_mmu_inst (
      .clk               (clk),
      .rst               (rst),
      .virt_addr_i       (fetch_addr_i),    // RAM read starts with the request
      .virt_addr_match_i (addr_r),
      .supervisor_i      (supervisor_r),
      .phys_addr_o       (mmu_phys_addr),
      .cache_inhibit_o   (mmu_cache_inhibit),
      .tlb_miss_o        (mmu_tlb_miss),
      .pagefault_o       (mmu_pagefault),
      .spr_addr_i        (spr_addr_i),
      .spr_we_i          (spr_we_i),
      .spr_stb_i         (spr_stb_i),
      .spr_dat_i         (spr_dat_i),
      .spr_dat_o         (spr_dat_o),
      .spr_ack_o         (spr_ack_o)
   );

   // Bypass gives virtual = physical and no flags
   assign xlate_valid_o   = req_valid_r;
   assign phys_addr_o     = enable_r ? mmu_phys_addr : addr_r;
   assign cache_inhibit_o = enable_r & mmu_cache_inhibit;
   assign tlb_miss_o      = enable_r & mmu_tlb_miss;
   assign pagefault_o     = enable_r & mmu_pagefault;

   property p_valid_after_req;
      @(posedge clk) disable iff (rst) xlate_valid_o |-> $past(fetch_req_i);
   endproperty
   a_valid_after_req: assert property (p_valid_after_req)
      else $error("fetch_xlate result valid without a request");

endmodule

// File: logic/itlb_mmu.sv
/*
 Direct-mapped single-way ITLB lookup with SPR access to both tables.
 RAMs are indexed by the current fetch address; results are formed one
 cycle later against the registered address. SPR read acks in cycle two.
*/
`timescale 1ns/1ps

module itlb_mmu #(
   parameter int set_width = 6
) (
   input  logic                     clk,
   input  logic                     rst,

   input  immu_tlb_pkg::word_t      virt_addr_i,        // Indexes the RAMs
   input  immu_tlb_pkg::word_t      virt_addr_match_i,  // Registered request address
   input  logic                     supervisor_i,       // Mode of the registered request

   output immu_tlb_pkg::word_t      phys_addr_o,
   output logic                     cache_inhibit_o,
   output logic                     tlb_miss_o,
   output logic                     pagefault_o,

   input  immu_spr_pkg::spr_addr_t  spr_addr_i,
   input  logic                     spr_we_i,
   input  logic                     spr_stb_i,
   input  immu_tlb_pkg::word_t      spr_dat_i,
   output immu_tlb_pkg::word_t      spr_dat_o,
   output logic                     spr_ack_o
);

   localparam int pb = immu_tlb_pkg::page_bits;

   logic [set_width-1:0]      fetch_index;
   logic [set_width-1:0]      spr_index;

   immu_tlb_pkg::tlb_word_u   match_dout;      // Fetch side, match view
   immu_tlb_pkg::tlb_word_u   trans_dout;      // Fetch side, translate view
   immu_tlb_pkg::word_t       match_spr_dout;
   immu_tlb_pkg::word_t       trans_spr_dout;

   logic match_cs;
   logic trans_cs;
   logic match_we;
   logic trans_we;
   logic write_ack;
   logic read_ack;
   logic read_ack_r;                           // Set in the first cycle of a read
   logic match_sel_r;                          // Read data source for the ack cycle

   // Set index from the low page number bits
   assign fetch_index = virt_addr_i[pb +: set_width];
   assign spr_index   = spr_addr_i[set_width-1:0];

   // SPR decode into two address groups
   assign match_cs = spr_stb_i &
                     (spr_addr_i >= immu_spr_pkg::itlb_match_base) &
                     (spr_addr_i <  immu_spr_pkg::itlb_trans_base);
   assign trans_cs = spr_stb_i &
                     (spr_addr_i >= immu_spr_pkg::itlb_trans_base) &
                     (spr_addr_i <  immu_spr_pkg::itlb_range_end);

   assign match_we = match_cs & spr_we_i;
   assign trans_we = trans_cs & spr_we_i;

   assign write_ack = match_we | trans_we;     // Same cycle as the RAM write

   // Read ack one cycle after the strobe, then drops so a new read waits again
   always_ff @(posedge clk) begin
      if (rst) begin
         read_ack_r <= 1'b0;
      end else begin
         read_ack_r <= (match_cs | trans_cs) & ~spr_we_i & ~read_ack_r;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         match_sel_r <= 1'b0;
      end else begin
         match_sel_r <= match_cs;              // Port B output belongs to this address
      end
   end

   assign read_ack  = read_ack_r & (match_cs | trans_cs) & ~spr_we_i;
   assign spr_ack_o = write_ack | read_ack;
   assign spr_dat_o = match_sel_r ? match_spr_dout : trans_spr_dout;

   // Lookup results valid the cycle after the index was applied
   assign tlb_miss_o = (match_dout.mr.vpn != virt_addr_match_i[immu_tlb_pkg::word_width-1:pb]) |
                       ~match_dout.mr.v;
   assign pagefault_o     = supervisor_i ? ~trans_dout.tr.sxe : ~trans_dout.tr.uxe;
   assign cache_inhibit_o = trans_dout.tr.ci;
   assign phys_addr_o     = {trans_dout.tr.ppn, virt_addr_match_i[pb-1:0]};

   // Match table
   tlb_dpram #(
      .addr_width (set_width),
      .data_width (immu_tlb_pkg::word_width)
   ) match_table (
      .clk      (clk),
      .addr_a_i (fetch_index),
      .dout_a_o (match_dout),
      .addr_b_i (spr_index),
      .we_b_i   (match_we),
      .din_b_i  (spr_dat_i),
      .dout_b_o (match_spr_dout)
   );

   // Translate table
   tlb_dpram #(
      .addr_width (set_width),
      .data_width (immu_tlb_pkg::word_width)
   ) trans_table (
      .clk      (clk),
      .addr_a_i (fetch_index),
      .dout_a_o (trans_dout),
      .addr_b_i (spr_index),
      .we_b_i   (trans_we),
      .din_b_i  (spr_dat_i),
      .dout_b_o (trans_spr_dout)
   );

   // Address groups must stay disjoint
   property p_cs_onehot;
      @(posedge clk) disable iff (rst) !(match_cs && trans_cs);
   endproperty
   a_cs_onehot: assert property (p_cs_onehot)
      else $error("itlb_mmu both table selects active");

   // Port B data was read with the previous address, so the master must hold it
   property p_read_ack_after_stb;
      @(posedge clk) disable iff (rst)
         read_ack |-> $past(spr_stb_i && !spr_we_i) && $stable(spr_addr_i);
   endproperty
   a_read_ack_after_stb: assert property (p_read_ack_after_stb)
      else $error("itlb_mmu read ack without a held strobe and address");

endmodule

// File: logic/tlb_dpram.sv
/*
 Single-clock dual-port RAM with registered outputs, no reset on contents.
 Port A reads only. Port B reads and writes, read-before-write.
*/
`timescale 1ns/1ps

module tlb_dpram #(
   parameter int addr_width = 6,
   parameter int data_width = 32
) (
   input  logic                  clk,
   input  logic [addr_width-1:0] addr_a_i,  // Fetch side index
   output logic [data_width-1:0] dout_a_o,
   input  logic [addr_width-1:0] addr_b_i,  // SPR side index
   input  logic                  we_b_i,
   input  logic [data_width-1:0] din_b_i,
   output logic [data_width-1:0] dout_b_o
);

   logic [data_width-1:0] mem [0:(1 << addr_width)-1];

   // Both ports in one block so a same-edge collision reads the old word
   always_ff @(posedge clk) begin
      dout_a_o <= mem[addr_a_i];
      dout_b_o <= mem[addr_b_i];         // Old data on a write cycle
      if (we_b_i) begin
         mem[addr_b_i] <= din_b_i;
      end
   end

   // An X address on a write would corrupt an unknown entry
   property p_no_x_write_addr;
      @(posedge clk) we_b_i |-> !$isunknown(addr_b_i);
   endproperty
   a_no_x_write_addr: assert property (p_no_x_write_addr)
      else $error("tlb_dpram write with unknown address");

endmodule

// File: logic/immu_tlb_pkg.sv
/*
 ITLB table word formats. One 32-bit word is read either as a match
 entry or as a translate entry, depending on the table it comes from.
 Page size is fixed at 8 KB and the operand width at 32.
*/
package immu_tlb_pkg;

   localparam int word_width = 32;                    // Operand width
   localparam int page_bits  = 13;                    // 8 KB page offset
   localparam int vpn_width  = word_width - page_bits; // Page number width

   typedef logic [word_width-1:0] word_t;

   // Match view, bits 31..13 VPN, bit 0 valid
   typedef struct packed {
      logic [vpn_width-1:0] vpn;   // Virtual page number
      logic [page_bits-2:0] rsvd;  // Bits 12..1 unused
      logic                 v;     // Entry valid
   } match_word_t;

   // Translate view
   typedef struct packed {
      logic [vpn_width-1:0] ppn;      // Physical page number
      logic [4:0]           rsvd_hi;  // Bits 12..8
      logic                 uxe;      // User execute enable, bit 7
      logic                 sxe;      // Supervisor execute enable, bit 6
      logic [3:0]           rsvd_lo;  // Bits 5..2
      logic                 ci;       // Cache inhibit, bit 1
      logic                 rsvd_0;   // Bit 0 unused
   } trans_word_t;

   // Same storage word, two decodings
   // mr = match register, tr = translate register
   typedef union packed {
      match_word_t mr;
      trans_word_t tr;
   } tlb_word_u;

endpackage

// File: logic/immu_spr_pkg.sv
/*
 SPR address map for the ITLB register groups, way 0 only.
 Match and translate groups are 0x80 words each, so set_width may not exceed 7.
*/
package immu_spr_pkg;

   // SPR bus address
   typedef logic [15:0] spr_addr_t;

   // Way-0 match registers, first entry
   localparam spr_addr_t itlb_match_base = 16'h1200;

   // Way-0 translate registers, also the end of the match group
   localparam spr_addr_t itlb_trans_base = 16'h1280;

   // First address past the translate group
   localparam spr_addr_t itlb_range_end  = 16'h1300;

   // Way 1 and up are not implemented.
   // Accesses at or above itlb_range_end are never acked.

endpackage
